//--- dv/decode_patterns.txt
// test id, inst, pc, rd, wdata, we, store, st_addr, st_data, trap, commit expected
// trap 0 none 1 ecall 2 ebreak 3 illegal, commit 0 marks strobes sent after ebreak
1 FFB00093 00001000 01 FFFFFFFB 1 0 00000000 00000000 0 1
1 FFF0B113 00001004 02 00000001 1 0 00000000 00000000 0 1
1 0F00F193 00001008 03 000000F0 1 0 00000000 00000000 0 1
1 4010D213 0000100C 04 FFFFFFFD 1 0 00000000 00000000 0 1
2 123452B7 00001010 05 12345000 1 0 00000000 00000000 0 1
2 00002317 00001014 06 00003014 1 0 00000000 00000000 0 1
3 006283B3 00001018 07 12348014 1 0 00000000 00000000 0 1
3 40138433 0000101C 08 12348019 1 0 00000000 00000000 0 1
3 008404B3 00001020 09 24690032 1 0 00000000 00000000 0 1
3 00448033 00001024 00 2469002F 1 0 00000000 00000000 0 1
3 40900533 00001028 0A DB96FFCE 1 0 00000000 00000000 0 1
4 0072A423 0000102C 00 00000000 0 1 12345008 12348014 0 1
4 FE132E23 00001030 00 00000000 0 1 00003010 FFFFFFFB 0 1
5 0000058B 00001034 0B 00000000 0 0 00000000 00000000 3 1
5 00000073 00001038 00 00000000 0 0 00000000 00000000 1 1
5 02108633 0000103C 0C 00000000 0 0 00000000 00000000 3 1
5 00C586B3 00001040 0D 00000000 1 0 00000000 00000000 0 1
6 00100073 00001044 00 00000000 0 0 00000000 00000000 2 1
6 00100713 00001048 0E 00000001 1 0 00000000 00000000 0 0
6 00000073 0000104C 00 00000000 0 0 00000000 00000000 1 0
6 ABCDE7B7 00001050 0F ABCDE000 1 0 00000000 00000000 0 0

//--- dv/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import core_types_pkg::*; #(
    parameter int num_pat = 1,
    parameter int num_col = 11
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pat_mem [num_pat*num_col],
    input  logic        commit_valid,
    input  commit_t     commit,
    input  logic        halt,
    output int          commit_count,
    output int          error_count
);

    // column layout of one pattern line
    localparam int col_id     = 0;
    localparam int col_pc     = 2;
    localparam int col_rd     = 3;
    localparam int col_wdata  = 4;
    localparam int col_we     = 5;
    localparam int col_store  = 6;
    localparam int col_addr   = 7;
    localparam int col_data   = 8;
    localparam int col_trap   = 9;
    localparam int col_commit = 10;

    int   n_commits = 0;
    int   n_errors  = 0;
    logic halt_exp  = 1'b0; // goes high the cycle after an ebreak commit

    assign commit_count = n_commits;
    assign error_count  = n_errors;

    function automatic string test_name(input logic [31:0] id);
        case (id)
            32'd1:   return "itype_arith";
            32'd2:   return "utype";
            32'd3:   return "rtype_dependency";
            32'd4:   return "store";
            32'd5:   return "illegal_and_ecall";
            32'd6:   return "ebreak_halt";
            default: return "unknown_test";
        endcase
    endfunction

    task automatic check_field(input string test, input int idx, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s pattern %0d %s expected %h actual %h",
                     test, idx, field, exp, act);
            n_errors++;
        end
    endtask

    always @(posedge clk) begin
        int    base;
        string name;
        if (rst_n) begin
            if (halt !== halt_exp) begin
                $display("[ERROR] ebreak_halt halt expected %b actual %b", halt_exp, halt);
                n_errors++;
            end
            if (commit_valid) begin
                if (n_commits >= num_pat ||
                    pat_mem[n_commits*num_col + col_commit] == 32'd0) begin
                    $display("unexpected commit at pc %h, no instruction was due to commit",
                             commit.pc);
                    n_errors++;
                end else begin
                    base = n_commits * num_col;
                    name = test_name(pat_mem[base + col_id]);
                    check_field(name, n_commits, "pc", pat_mem[base + col_pc], commit.pc);
                    check_field(name, n_commits, "rd", pat_mem[base + col_rd],
                                {27'b0, commit.rd});
                    check_field(name, n_commits, "wdata", pat_mem[base + col_wdata],
                                commit.wdata);
                    check_field(name, n_commits, "we", pat_mem[base + col_we],
                                {31'b0, commit.we});
                    check_field(name, n_commits, "store", pat_mem[base + col_store],
                                {31'b0, commit.store});
                    check_field(name, n_commits, "st_addr", pat_mem[base + col_addr],
                                commit.st_addr);
                    check_field(name, n_commits, "st_data", pat_mem[base + col_data],
                                commit.st_data);
                    check_field(name, n_commits, "trap", pat_mem[base + col_trap],
                                {30'b0, commit.trap});
                    if (pat_mem[base + col_trap] == 32'd2) begin
                        halt_exp = 1'b1;
                    end
                end
                n_commits++;
            end
        end
    end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1; // flops leave reset one edge after release
    end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import core_types_pkg::*; ();

    localparam int num_pat    = 21;
    localparam int num_col    = 11;
    localparam int limit      = 4 * num_pat + 20;
    localparam int col_id     = 0;
    localparam int col_inst   = 1;
    localparam int col_pc     = 2;
    localparam int col_commit = 10;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        commit_valid;
    commit_t     commit;
    logic        halt;
    logic [31:0] pat_mem [num_pat*num_col];
    int          commit_count;
    int          error_count;
    int          exp_commits;
    int          cycles;
    bit          run_done;
    integer      seed;

    tb_clock #(.half_period(10), .reset_cycles(5)) clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_core_top rv_core_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halt         (halt)
    );

    tb_checker #(.num_pat(num_pat), .num_col(num_col)) commit_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .pat_mem      (pat_mem),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halt         (halt),
        .commit_count (commit_count),
        .error_count  (error_count)
    );

    task automatic finish_run(input bit timed_out);
        int total;
        total    = error_count + (timed_out ? 1 : 0);
        run_done = 1'b1;
        $display("commits %0d of %0d, errors %0d", commit_count, exp_commits, total);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        if (rst_n && !run_done) begin
            cycles++;
            if (cycles >= limit) begin
                $display("timeout after %0d cycles, halt is %b", cycles, halt);
                for (int k = commit_count; k < exp_commits; k++) begin
                    $display("commit for pattern %0d at pc %h never arrived",
                             k, pat_mem[k*num_col + col_pc]);
                end
                finish_run(1'b1);
            end
        end
    end

    initial begin
        int          gap;
        logic [31:0] rnd;
        bit          halt_waited;
        inst_valid  = 1'b0;
        inst        = '0;
        pc          = '0;
        seed        = 32'h4274;
        cycles      = 0;
        run_done    = 1'b0;
        exp_commits = 0;
        halt_waited = 1'b0;
        $readmemh("dv/decode_patterns.txt", pat_mem);
        for (int i = 0; i < num_pat; i++) begin
            if (pat_mem[i*num_col + col_commit] != 32'd0) exp_commits++;
        end
        wait (rst_n === 1'b1);

        for (int i = 0; i < num_pat; i++) begin
            rnd = $random(seed);
            // dependency group goes back to back
            gap = (pat_mem[i*num_col + col_id] == 32'd3) ? 0 : int'(rnd % 3);
            repeat (gap) begin
                @(posedge clk);
                inst_valid <= 1'b0;
            end
            if (pat_mem[i*num_col + col_commit] == 32'd0 && !halt_waited) begin
                @(posedge clk);
                inst_valid <= 1'b0;
                while (halt !== 1'b1) @(negedge clk); // these strobes must hit a halted core
                halt_waited = 1'b1;
            end
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= pat_mem[i*num_col + col_inst];
            pc         <= pat_mem[i*num_col + col_pc];
        end
        @(posedge clk);
        inst_valid <= 1'b0;

        while (commit_count < exp_commits) @(negedge clk);
        repeat (8) @(negedge clk); // window for stray commits after halt
        finish_run(1'b0);
    end

endmodule

//--- logic/commit_stage.sv
`timescale 1ns/1ps

module commit_stage import core_types_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_valid,
    input  commit_t     result,
    output logic        commit_valid,
    output commit_t     commit,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        halt
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            halt         <= 1'b0;
        end else begin
            commit_valid <= fetch_valid;
            if (commit_valid && commit.trap == trap_ebreak) begin
                halt <= 1'b1; // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            commit <= result;
        end
    end

    // register write lands on the same edge that captures the record,
    // so the next instruction reads the new value without forwarding
    assign rf_we    = fetch_valid & result.we;
    assign rf_waddr = result.rd;
    assign rf_wdata = result.wdata;

endmodule

//--- logic/core_types_pkg.sv
package core_types_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        trap_none,
        trap_ecall,
        trap_ebreak,
        trap_illegal
    } trap_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] pc;
        inst_fmt_e   fmt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        use_imm;   // operand b from imm
        logic        use_pc;    // operand a from pc
        logic        reg_we;
        logic        is_store;
        logic        is_ebreak;
        logic        is_ecall;
        logic        illegal;
    } decode_pkt_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        we;
        logic        store;
        logic [31:0] st_addr;
        logic [31:0] st_data;
        trap_e       trap;
    } commit_t;

endpackage

//--- logic/exec_alu.sv
`timescale 1ns/1ps

module exec_alu import rv_isa_pkg::*, core_types_pkg::*; (
    input  decode_pkt_t dec,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    output commit_t     result
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic        sys;
    logic        st_ok;

    assign op_a = dec.use_pc ? dec.pc : rdata1;   // auipc
    assign op_b = dec.use_imm ? dec.imm : rdata2;

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sltu:   alu_out = {31'b0, op_a < op_b};
            alu_and:    alu_out = op_a & op_b;
            alu_sra:    alu_out = $signed(op_a) >>> op_b[4:0];
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    assign sys   = (dec.fmt == fmt_n);
    assign st_ok = dec.is_store && !dec.illegal;

    always_comb begin
        result       = '0;
        result.pc    = dec.pc;
        result.rd    = dec.rd;
        result.we    = dec.reg_we && !dec.illegal && !sys;
        result.wdata = result.we ? alu_out : '0;
        result.store = st_ok;
        if (st_ok) begin
            result.st_addr = alu_out; // rs1 + imm_s
            result.st_data = rdata2;
        end
        // illegal wins over the system calls
        if (dec.illegal) begin
            result.trap = trap_illegal;
        end else if (dec.is_ebreak) begin
            result.trap = trap_ebreak;
        end else if (dec.is_ecall) begin
            result.trap = trap_ecall;
        end else begin
            result.trap = trap_none;
        end
    end

endmodule

//--- logic/inst_capture.sv
`timescale 1ns/1ps

module inst_capture import core_types_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        halt,
    output logic        fetch_valid,
    output fetch_pkt_t  fetch
);

    logic take;

    // nothing enters once halted
    assign take = inst_valid & ~halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fetch.pc   <= pc;
            fetch.inst <= inst;
        end
    end

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import rv_isa_pkg::*, core_types_pkg::*; (
    input  fetch_pkt_t  fetch,
    output decode_pkt_t dec
);

    logic [31:0] inst;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_s;

    assign inst   = fetch.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]}; // split field

    always_comb begin
        dec        = '0;
        dec.pc     = fetch.pc;
        dec.fmt    = fmt_bad;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.alu_op = alu_add;
        case (opcode)
            op_imm: begin
                dec.fmt     = fmt_i;
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
                case (funct3)
                    f3_add:  dec.alu_op = alu_add;
                    f3_sltu: dec.alu_op = alu_sltu; // imm compared after sign extension
                    f3_and:  dec.alu_op = alu_and;
                    f3_sra: begin
                        // srli is not supported
                        dec.alu_op  = alu_sra;
                        dec.illegal = (funct7 != f7_alt);
                    end
                    default: dec.illegal = 1'b1;
                endcase
            end
            op_reg: begin
                dec.fmt    = fmt_r;
                dec.reg_we = 1'b1;
                if (funct3 == f3_add && funct7 == f7_base) begin
                    dec.alu_op = alu_add;
                end else if (funct3 == f3_add && funct7 == f7_alt) begin
                    dec.alu_op = alu_sub;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            op_lui: begin
                dec.fmt     = fmt_u;
                dec.rs1     = 5'd0; // field holds immediate bits
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.alu_op  = alu_pass_b;
                dec.reg_we  = 1'b1;
            end
            op_auipc: begin
                dec.fmt     = fmt_u;
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.use_pc  = 1'b1;
                dec.reg_we  = 1'b1;
            end
            op_store: begin
                dec.fmt      = fmt_s;
                dec.rd       = 5'd0; // rd bits are part of the immediate
                dec.imm      = imm_s;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                dec.illegal  = (funct3 != f3_sw);
            end
            op_system: begin
                dec.fmt       = fmt_n;
                dec.is_ecall  = (inst[31:7] == ecall_field);
                dec.is_ebreak = (inst[31:7] == ebreak_field);
                dec.illegal   = !dec.is_ecall && !dec.is_ebreak;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- logic/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import core_types_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic        commit_valid,
    output commit_t     commit,
    output logic        halt
);

    logic        fetch_valid;
    fetch_pkt_t  fetch;
    decode_pkt_t dec;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    commit_t     result;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    inst_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .halt        (halt),
        .fetch_valid (fetch_valid),
        .fetch       (fetch)
    );

    inst_decoder u_decoder (
        .fetch (fetch),
        .dec   (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exec_alu u_alu (
        .dec    (dec),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .result (result)
    );

    commit_stage u_commit (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .result       (result),
        .commit_valid (commit_valid),
        .commit       (commit),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .halt         (halt)
    );

endmodule

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011, // addi sltiu andi srai
        op_reg    = 7'b0110011, // add sub
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011, // sw only
        op_system = 7'b1110011  // ecall ebreak
    } opcode_e;

    // format class of the decoded word
    typedef enum logic [2:0] {
        fmt_i   = 3'b000,
        fmt_n   = 3'b001,
        fmt_u   = 3'b010,
        fmt_r   = 3'b011,
        fmt_s   = 3'b100,
        fmt_bad = 3'b111
    } inst_fmt_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_sltu,
        alu_and,
        alu_sra,
        alu_pass_b // lui
    } alu_op_e;

    localparam logic [2:0] f3_add  = 3'b000; // addi, add, sub
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_sra  = 3'b101;
    localparam logic [2:0] f3_sw   = 3'b010;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, srai

    // inst[31:7] of the two system calls
    localparam logic [24:0] ecall_field  = 25'b0000000000000000000000000;
    localparam logic [24:0] ebreak_field = 25'b0000000000010000000000000;

endpackage

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_top \
    -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- sim.f
logic/rv_isa_pkg.sv
logic/core_types_pkg.sv
logic/inst_capture.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/exec_alu.sv
logic/commit_stage.sv
logic/rv_core_top.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv
